/* common/engine_op_pkg.sv */
package engine_op_pkg;

	// job kind where code 0 is never accepted
	typedef enum logic [1:0] {
		OP_NONE  = 2'd0,
		OP_CONV  = 2'd1,
		OP_MPOOL = 2'd2,
		OP_APOOL = 2'd3
	} op_t;

	// controller states
	typedef enum logic [2:0] {
		ST_IDLE  = 3'd0, // waiting for a start strobe
		ST_READ  = 3'd1, // one read per element of the window
		ST_DRAIN = 3'd2, // last samples still in the lanes
		ST_WRITE = 3'd3, // writeback busy with this window
		ST_DONE  = 3'd4  // line finished, single cycle
	} ctrl_state_t;

endpackage

/* common/engine_data_pkg.sv */
package engine_data_pkg;

	// operand and result word
	localparam int DATA_W = 16;
	typedef logic signed [DATA_W-1:0] word_t;

	// lane accumulator
	localparam int ACC_W = 32;
	typedef logic signed [ACC_W-1:0] acc_t;

	// data and weight memory read address
	localparam int ADDR_W = 10;
	typedef logic [ADDR_W-1:0] addr_t;

endpackage

/* engine/engine_ctrl.sv */
`timescale 1ns/100ps

module engine_ctrl
	import engine_op_pkg::*;
	import engine_data_pkg::*;
(
	input  logic        clk,
	input  logic        rst,
	input  logic        i_start,
	input  op_t         i_op,
	input  logic [7:0]  i_kernel_size,
	input  logic [3:0]  i_stride,
	input  logic [7:0]  i_o_side,
	input  logic        i_lanes_done,
	input  logic        i_wb_idle,
	output logic        o_busy,
	output logic        o_rd_en,
	output addr_t       o_d_addr,
	output addr_t       o_w_addr,
	output logic        o_lane_sample,
	output logic        o_lane_first,
	output logic        o_lane_last,
	output logic        o_line_done
);

	ctrl_state_t state;

	// job captured at start
	logic [7:0] kernel_r;
	logic [3:0] stride_r;
	logic [7:0] o_side_r;

	logic [7:0] elem; // element inside the window
	logic [7:0] win; // window inside the line
	addr_t      base; // data address of element 0

	logic start_ok;
	logic last_elem;
	logic last_win;

	assign start_ok  = i_start && (i_op != OP_NONE);
	assign last_elem = (elem == kernel_r - 8'd1);
	assign last_win  = (win == o_side_r - 8'd1);

	// addresses follow the counters directly
	assign o_rd_en  = (state == ST_READ);
	assign o_d_addr = base + addr_t'(elem);
	assign o_w_addr = addr_t'(elem);

	// ST_DONE already counts as free, line_done marks it
	assign o_busy      = (state != ST_IDLE) && (state != ST_DONE);
	assign o_line_done = (state == ST_DONE);

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state    <= ST_IDLE;
			kernel_r <= 8'd0;
			stride_r <= 4'd0;
			o_side_r <= 8'd0;
			elem     <= 8'd0;
			win      <= 8'd0;
			base     <= '0;
		end else begin
			case (state)
				ST_IDLE, ST_DONE: begin
					if (start_ok) begin
						kernel_r <= i_kernel_size;
						stride_r <= i_stride;
						o_side_r <= i_o_side;
						elem     <= 8'd0;
						win      <= 8'd0;
						base     <= '0;
						state    <= ST_READ;
					end else begin
						state <= ST_IDLE;
					end
				end
				ST_READ: begin
					if (last_elem) begin
						elem  <= 8'd0;
						state <= ST_DRAIN;
					end else begin
						elem <= elem + 8'd1;
					end
				end
				ST_DRAIN: begin
					if (i_lanes_done)
						state <= ST_WRITE;
				end
				ST_WRITE: begin
					// next window only once the words are out
					if (i_wb_idle) begin
						if (last_win) begin
							state <= ST_DONE;
						end else begin
							win   <= win + 8'd1;
							base  <= base + addr_t'(stride_r);
							state <= ST_READ;
						end
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	// memory answers one cycle after the read, so the lane strobes lag by one
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			o_lane_sample <= 1'b0;
			o_lane_first  <= 1'b0;
			o_lane_last   <= 1'b0;
		end else begin
			o_lane_sample <= o_rd_en;
			o_lane_first  <= o_rd_en && (elem == 8'd0);
			o_lane_last   <= o_rd_en && last_elem;
		end
	end

endmodule

/* engine/lane_array.sv */
`timescale 1ns/100ps

module lane_array
	import engine_op_pkg::*;
	import engine_data_pkg::*;
#(
	parameter int LANES = 8
) (
	input  logic                    clk,
	input  logic                    rst,
	input  op_t                     i_op,
	input  logic                    i_sample,
	input  logic                    i_first,
	input  logic                    i_last,
	input  word_t [LANES-1:0]       i_data,
	input  word_t [LANES-1:0]       i_weight,
	output logic                    o_done,
	output acc_t  [LANES-1:0]       o_results
);

	for (genvar l = 0; l < LANES; l++) begin : g_lane
		word_t d;
		word_t w;
		acc_t  d_ext;
		acc_t  prod;
		acc_t  acc;

		assign d     = i_data[l];
		assign w     = i_weight[l];
		assign d_ext = d; // sign extended
		assign prod  = d * w; // full 32 bit signed product

		always_ff @(posedge clk) begin
			if (i_sample) begin
				case (i_op)
					OP_CONV: begin
						if (i_first)
							acc <= prod;
						else
							acc <= acc + prod;
					end
					OP_MPOOL: begin
						// first element always loads
						if (i_first || (d_ext > acc))
							acc <= d_ext;
					end
					OP_APOOL: begin
						if (i_first)
							acc <= d_ext;
						else
							acc <= acc + d_ext;
					end
					default: ;
				endcase
			end
		end

		assign o_results[l] = acc;
	end

	// window complete one cycle after its last sample
	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			o_done <= 1'b0;
		else
			o_done <= i_sample && i_last;
	end

endmodule

/* engine/writeback.sv */
`timescale 1ns/100ps

module writeback
	import engine_op_pkg::*;
	import engine_data_pkg::*;
#(
	parameter int LANES     = 8,
	parameter int FRAC_BITS = 8
) (
	input  logic              clk,
	input  logic              rst,
	input  op_t               i_op,
	input  word_t             i_bias,
	input  logic [7:0]        i_kernel_size,
	input  logic              i_valid,
	input  acc_t [LANES-1:0]  i_results,
	output logic              o_idle,
	output logic              o_out_valid,
	output word_t             o_out_word
);

	localparam int LW = (LANES > 1) ? $clog2(LANES) : 1;
	localparam int CW = $clog2(ACC_W);
	localparam logic signed [ACC_W:0] W_MAX = (2 ** (DATA_W - 1)) - 1;
	localparam logic signed [ACC_W:0] W_MIN = -(2 ** (DATA_W - 1));

	localparam logic [1:0] WB_IDLE = 2'd0;
	localparam logic [1:0] WB_CONV = 2'd1; // bias, saturate, relu
	localparam logic [1:0] WB_POOL = 2'd2; // max-pool serializer
	localparam logic [1:0] WB_DIV  = 2'd3; // average-pool divider

	logic [1:0]    phase;
	logic [LW-1:0] idx;
	logic [LW-1:0] idx_nx;
	logic [CW-1:0] cnt;

	acc_t                    lane_sum;
	acc_t                    sum_r;
	logic signed [ACC_W:0]   conv_pre;

	// restoring divider whose remainder stays below the 8 bit divisor
	logic [ACC_W-1:0]        quo;
	logic [ACC_W-1:0]        quo_nx;
	logic [8:0]              rem;
	logic [8:0]              rem_sh;
	logic [8:0]              rem_nx;
	logic                    geq;
	logic                    neg;
	logic signed [ACC_W:0]   div_q;

	function automatic word_t sat16(input logic signed [ACC_W:0] v);
		if (v > W_MAX)
			return W_MAX[DATA_W-1:0];
		else if (v < W_MIN)
			return W_MIN[DATA_W-1:0];
		return v[DATA_W-1:0];
	endfunction

	function automatic logic [ACC_W-1:0] acc_mag(input acc_t a);
		return a[ACC_W-1] ? -a : a;
	endfunction

	always_comb begin
		lane_sum = '0;
		for (int l = 0; l < LANES; l++)
			lane_sum = lane_sum + i_results[l]; // wraps at 32 bits
	end

	assign conv_pre = (sum_r >>> FRAC_BITS) + i_bias;

	assign rem_sh = {rem[7:0], quo[ACC_W-1]};
	assign geq    = (rem_sh >= {1'b0, i_kernel_size});
	assign rem_nx = geq ? rem_sh - {1'b0, i_kernel_size} : rem_sh;
	assign quo_nx = {quo[ACC_W-2:0], geq};
	assign div_q  = neg ? -$signed({1'b0, quo_nx}) : $signed({1'b0, quo_nx});

	assign idx_nx = idx + LW'(1);
	assign o_idle = (phase == WB_IDLE);

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			phase       <= WB_IDLE;
			idx         <= '0;
			cnt         <= '0;
			o_out_valid <= 1'b0;
		end else begin
			o_out_valid <= 1'b0;
			case (phase)
				WB_IDLE: begin
					if (i_valid) begin
						case (i_op)
							OP_CONV: phase <= WB_CONV;
							OP_MPOOL: begin
								// lane 0 leaves right away
								o_out_valid <= 1'b1;
								idx         <= LW'(1);
								phase       <= (LANES > 1) ? WB_POOL : WB_IDLE;
							end
							OP_APOOL: begin
								idx   <= '0;
								cnt   <= '0;
								phase <= WB_DIV;
							end
							default: ;
						endcase
					end
				end
				WB_CONV: begin
					o_out_valid <= 1'b1;
					phase       <= WB_IDLE;
				end
				WB_POOL: begin
					o_out_valid <= 1'b1;
					if (idx == LW'(LANES - 1))
						phase <= WB_IDLE;
					else
						idx <= idx_nx;
				end
				WB_DIV: begin
					cnt <= cnt + CW'(1);
					if (cnt == CW'(ACC_W - 1)) begin
						o_out_valid <= 1'b1;
						cnt         <= '0;
						if (idx == LW'(LANES - 1))
							phase <= WB_IDLE;
						else
							idx <= idx_nx;
					end
				end
				default: phase <= WB_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		case (phase)
			WB_IDLE: begin
				if (i_valid) begin
					sum_r      <= lane_sum;
					o_out_word <= i_results[0][DATA_W-1:0];
					quo        <= acc_mag(i_results[0]);
					neg        <= i_results[0][ACC_W-1];
					rem        <= '0;
				end
			end
			WB_CONV: o_out_word <= (conv_pre < 0) ? '0 : sat16(conv_pre);
			WB_POOL: o_out_word <= i_results[idx][DATA_W-1:0]; // truncated
			WB_DIV: begin
				if (cnt == CW'(ACC_W - 1)) begin
					o_out_word <= sat16(div_q);
					rem        <= '0;
					// load the next lane while this word goes out
					if (idx != LW'(LANES - 1)) begin
						quo <= acc_mag(i_results[idx_nx]);
						neg <= i_results[idx_nx][ACC_W-1];
					end
				end else begin
					quo <= quo_nx;
					rem <= rem_nx;
				end
			end
			default: ;
		endcase
	end

endmodule

/* source/cnn_engine_top.sv */
`timescale 1ns/100ps

module cnn_engine_top
	import engine_op_pkg::*;
	import engine_data_pkg::*;
#(
	parameter int LANES     = 8,
	parameter int FRAC_BITS = 8
) (
	input  logic               clk,
	input  logic               rst,
	input  logic               i_start,
	input  op_t                i_op,
	input  logic [7:0]         i_kernel_size,
	input  logic [3:0]         i_stride,
	input  logic [7:0]         i_o_side,
	input  word_t              i_bias,
	input  word_t [LANES-1:0]  i_data,
	input  word_t [LANES-1:0]  i_weight,
	output logic               o_busy,
	output logic               o_rd_en,
	output addr_t              o_d_addr,
	output addr_t              o_w_addr,
	output logic               o_out_valid,
	output word_t              o_out_word,
	output logic               o_line_done
);

	logic              lane_sample;
	logic              lane_first;
	logic              lane_last;
	logic              lanes_done;
	acc_t [LANES-1:0]  lane_results;
	logic              wb_idle;

	// job sequencing and read addresses
	engine_ctrl u_ctrl (
		.clk           (clk),
		.rst           (rst),
		.i_start       (i_start),
		.i_op          (i_op),
		.i_kernel_size (i_kernel_size),
		.i_stride      (i_stride),
		.i_o_side      (i_o_side),
		.i_lanes_done  (lanes_done),
		.i_wb_idle     (wb_idle),
		.o_busy        (o_busy),
		.o_rd_en       (o_rd_en),
		.o_d_addr      (o_d_addr),
		.o_w_addr      (o_w_addr),
		.o_lane_sample (lane_sample),
		.o_lane_first  (lane_first),
		.o_lane_last   (lane_last),
		.o_line_done   (o_line_done)
	);

	lane_array #(
		.LANES (LANES)
	) u_lanes (
		.clk       (clk),
		.rst       (rst),
		.i_op      (i_op),
		.i_sample  (lane_sample),
		.i_first   (lane_first),
		.i_last    (lane_last),
		.i_data    (i_data),
		.i_weight  (i_weight),
		.o_done    (lanes_done),
		.o_results (lane_results)
	);

	writeback #(
		.LANES     (LANES),
		.FRAC_BITS (FRAC_BITS)
	) u_wb (
		.clk           (clk),
		.rst           (rst),
		.i_op          (i_op),
		.i_bias        (i_bias),
		.i_kernel_size (i_kernel_size),
		.i_valid       (lanes_done),
		.i_results     (lane_results),
		.o_idle        (wb_idle),
		.o_out_valid   (o_out_valid),
		.o_out_word    (o_out_word)
	);

endmodule

/* verif/cnn_engine_tb.sv */
`timescale 1ns/100ps

module cnn_engine_tb
	import engine_op_pkg::*;
	import engine_data_pkg::*;
();

	localparam int LANES     = 8;
	localparam int FRAC_BITS = 8;
	localparam int MEM_DEPTH = 1 << ADDR_W;
	localparam int TIMEOUT   = 20000; // cycles per line

	logic              clk;
	logic              rst;
	logic              i_start;
	op_t               i_op;
	logic [7:0]        i_kernel_size;
	logic [3:0]        i_stride;
	logic [7:0]        i_o_side;
	word_t             i_bias;
	word_t [LANES-1:0] i_data;
	word_t [LANES-1:0] i_weight;
	logic              o_busy;
	logic              o_rd_en;
	addr_t             o_d_addr;
	addr_t             o_w_addr;
	logic              o_out_valid;
	word_t             o_out_word;
	logic              o_line_done;

	// memory images with one word per lane and address
	word_t data_mem   [0:MEM_DEPTH-1][0:LANES-1];
	word_t weight_mem [0:MEM_DEPTH-1][0:LANES-1];

	word_t exp_words [$];
	addr_t exp_daddr [$];
	addr_t exp_waddr [$];

	logic [31:0] lcg_state = 32'h9c8f77a3;
	int errors       = 0;
	int err_mark     = 0;
	int tests_run    = 0;
	int tests_failed = 0;
	int words_seen   = 0;
	int words_owed   = 0; // words still due from windows already read
	int rd_count     = 0;
	int job_k        = 1;
	int job_per_win  = 1;

	cnn_engine_top #(
		.LANES     (LANES),
		.FRAC_BITS (FRAC_BITS)
	) DUT (
		.clk           (clk),
		.rst           (rst),
		.i_start       (i_start),
		.i_op          (i_op),
		.i_kernel_size (i_kernel_size),
		.i_stride      (i_stride),
		.i_o_side      (i_o_side),
		.i_bias        (i_bias),
		.i_data        (i_data),
		.i_weight      (i_weight),
		.o_busy        (o_busy),
		.o_rd_en       (o_rd_en),
		.o_d_addr      (o_d_addr),
		.o_w_addr      (o_w_addr),
		.o_out_valid   (o_out_valid),
		.o_out_word    (o_out_word),
		.o_line_done   (o_line_done)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// both memories answer one cycle after the address
	always @(posedge clk) begin
		if (o_rd_en) begin
			for (int l = 0; l < LANES; l++) begin
				i_data[l]   <= data_mem[o_d_addr][l];
				i_weight[l] <= weight_mem[o_w_addr][l];
			end
		end
	end

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	// larger shift gives smaller operands
	task automatic fill_memories(input int data_shift, input int weight_shift);
		logic [31:0] r;
		for (int a = 0; a < MEM_DEPTH; a++) begin
			for (int l = 0; l < LANES; l++) begin
				r = lcg_next();
				data_mem[a][l] = word_t'($signed(r[31:16]) >>> data_shift);
				r = lcg_next();
				weight_mem[a][l] = word_t'($signed(r[31:16]) >>> weight_shift);
			end
		end
	endtask

	// expected reads and words of one line
	function automatic void build_expected(input op_t op, input int k, input int s,
			input int side, input int bias);
		int     acc;
		int     total;
		longint scaled;
		word_t  d;
		for (int w = 0; w < side; w++) begin
			for (int e = 0; e < k; e++) begin
				exp_daddr.push_back(addr_t'(w * s + e));
				exp_waddr.push_back(addr_t'(e));
			end
			total = 0;
			for (int l = 0; l < LANES; l++) begin
				acc = 0;
				for (int e = 0; e < k; e++) begin
					d = data_mem[w * s + e][l];
					case (op)
						OP_CONV: acc = acc + int'(d) * int'(weight_mem[e][l]);
						OP_MPOOL: begin
							if (e == 0 || int'(d) > acc)
								acc = int'(d);
						end
						default: acc = acc + int'(d);
					endcase
				end
				total = total + acc; // wraps like the hardware sum
				if (op == OP_MPOOL)
					exp_words.push_back(word_t'(acc));
				else if (op == OP_APOOL)
					exp_words.push_back(word_t'(acc / k)); // truncates toward zero
			end
			if (op == OP_CONV) begin
				scaled = longint'(total >>> FRAC_BITS) + bias;
				if (scaled < 0)
					scaled = 0; // relu
				else if (scaled > 32767)
					scaled = 32767;
				exp_words.push_back(word_t'(scaled));
			end
		end
	endfunction

	// comparing process for reads and output words
	always @(posedge clk) begin : compare
		addr_t exp_d;
		addr_t exp_w;
		word_t exp_word;
		if (!rst) begin
			if (o_rd_en) begin
				if (words_owed != 0) begin
					$display("error at %0t: read issued while writeback still owes %0d words",
						$time, words_owed);
					errors++;
				end
				if (exp_daddr.size() == 0) begin
					$display("error at %0t: read cycle when no read was expected", $time);
					errors++;
				end else begin
					exp_d = exp_daddr.pop_front();
					exp_w = exp_waddr.pop_front();
					if (o_d_addr !== exp_d) begin
						$display("mismatch at %0t: o_d_addr got %0d expected %0d",
							$time, o_d_addr, exp_d);
						errors++;
					end
					if (o_w_addr !== exp_w) begin
						$display("mismatch at %0t: o_w_addr got %0d expected %0d",
							$time, o_w_addr, exp_w);
						errors++;
					end
				end
				rd_count++;
				if (rd_count == job_k) begin // last read of the window
					rd_count = 0;
					words_owed += job_per_win;
				end
			end
			if (o_out_valid) begin
				words_seen++;
				if (words_owed > 0)
					words_owed--;
				if (exp_words.size() == 0) begin
					$display("error at %0t: output word %0d when none was expected",
						$time, o_out_word);
					errors++;
				end else begin
					exp_word = exp_words.pop_front();
					if (o_out_word !== exp_word) begin
						$display("mismatch at %0t: o_out_word got %0d expected %0d",
							$time, o_out_word, exp_word);
						errors++;
					end
				end
			end
		end
	end

	task automatic compare_level(input string name, input logic [31:0] got,
			input logic [31:0] want);
		if (got !== want) begin
			$display("mismatch at %0t: %s got %0d expected %0d", $time, name, got, want);
			errors++;
		end
	endtask

	task automatic start_job(input op_t op, input int k, input int s, input int side,
			input int bias);
		job_k       = k;
		job_per_win = (op == OP_CONV) ? 1 : LANES;
		@(posedge clk);
		i_op          <= op;
		i_kernel_size <= 8'(k);
		i_stride      <= 4'(s);
		i_o_side      <= 8'(side);
		i_bias        <= word_t'(bias);
		i_start       <= 1'b1;
		@(posedge clk);
		i_start <= 1'b0;
	endtask

	task automatic wait_line_done();
		int  n;
		logic seen;
		n    = 0;
		seen = 1'b0;
		while (!seen && n < TIMEOUT) begin
			@(posedge clk);
			n++;
			if (o_line_done === 1'b1) begin
				seen = 1'b1;
				compare_level("o_busy", o_busy, 1'b0); // falls with line_done
			end
		end
		if (!seen) begin
			$display("error at %0t: o_line_done did not arrive within %0d cycles",
				$time, TIMEOUT);
			$display("Regression failed");
			$finish;
		end
	endtask

	// DUT must stay idle for the given number of cycles
	task automatic expect_quiet(input int cycles);
		repeat (cycles) begin
			@(posedge clk);
			compare_level("o_busy", o_busy, 1'b0);
		end
	endtask

	task automatic begin_test();
		err_mark   = errors;
		words_seen = 0;
	endtask

	task automatic end_test(input string name, input int want_words);
		if (exp_words.size() != 0 || exp_daddr.size() != 0) begin
			$display("error at %0t: %0d words and %0d reads were expected but never seen",
				$time, exp_words.size(), exp_daddr.size());
			errors++;
		end
		if (words_seen != want_words) begin
			$display("mismatch at %0t: word count got %0d expected %0d",
				$time, words_seen, want_words);
			errors++;
		end
		exp_words.delete();
		exp_daddr.delete();
		exp_waddr.delete();
		words_owed = 0;
		rd_count   = 0;
		tests_run++;
		if (errors != err_mark) begin
			tests_failed++;
			$display("test %s: FAILED with %0d errors", name, errors - err_mark);
		end else begin
			$display("test %s: ok", name);
		end
	endtask

	initial begin
		rst           = 1'b1;
		i_start       = 1'b0;
		i_op          = OP_NONE;
		i_kernel_size = 8'd1;
		i_stride      = 4'd1;
		i_o_side      = 8'd1;
		i_bias        = '0;
		i_data        = '0;
		i_weight      = '0;
		repeat (5) @(posedge clk);
		rst <= 1'b0;

		begin_test();
		@(posedge clk);
		compare_level("o_busy", o_busy, 1'b0);
		compare_level("o_rd_en", o_rd_en, 1'b0);
		compare_level("o_out_valid", o_out_valid, 1'b0);
		compare_level("o_line_done", o_line_done, 1'b0);
		compare_level("o_d_addr", o_d_addr, 32'd0);
		compare_level("o_w_addr", o_w_addr, 32'd0);
		start_job(OP_NONE, 3, 1, 2, 0); // invalid op code
		expect_quiet(20);
		end_test("reset_and_invalid_op", 0);

		begin_test();
		fill_memories(12, 12);
		build_expected(OP_CONV, 9, 1, 6, 5);
		start_job(OP_CONV, 9, 1, 6, 5);
		wait_line_done();
		end_test("conv_stride1", 6);

		begin_test();
		fill_memories(3, 3); // products near 2**24
		// window 0 saturates and window 7 falls to zero
		for (int e = 0; e < 9; e++) begin
			for (int l = 0; l < LANES; l++) begin
				data_mem[e][l]      = weight_mem[e][l];
				data_mem[14 + e][l] = -weight_mem[e][l];
			end
		end
		build_expected(OP_CONV, 9, 2, 8, -2000);
		start_job(OP_CONV, 9, 2, 8, -2000);
		wait_line_done();
		end_test("conv_extremes", 8);

		begin_test();
		fill_memories(0, 0);
		build_expected(OP_MPOOL, 4, 2, 5, 0);
		start_job(OP_MPOOL, 4, 2, 5, 0);
		wait_line_done();
		end_test("max_pool", 5 * LANES);

		begin_test();
		fill_memories(0, 0);
		build_expected(OP_APOOL, 7, 3, 4, 0);
		start_job(OP_APOOL, 7, 3, 4, 0);
		wait_line_done();
		end_test("avg_pool", 4 * LANES);

		begin_test();
		fill_memories(10, 10);
		build_expected(OP_CONV, 3, 15, 10, 0); // widest stride
		start_job(OP_CONV, 3, 15, 10, 0);
		wait_line_done();
		end_test("addresses", 10);

		begin_test();
		fill_memories(0, 0);
		build_expected(OP_MPOOL, 5, 1, 3, 0);
		start_job(OP_MPOOL, 5, 1, 3, 0);
		repeat (3) @(posedge clk);
		compare_level("o_busy", o_busy, 1'b1);
		i_start <= 1'b1; // must be ignored
		@(posedge clk);
		i_start <= 1'b0;
		wait_line_done();
		expect_quiet(20);
		end_test("start_while_busy", 3 * LANES);

		$display("tests run %0d, tests failed %0d, errors %0d",
			tests_run, tests_failed, errors);
		if (errors == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

endmodule

/* cnn_engine_top.f */
common/engine_op_pkg.sv
common/engine_data_pkg.sv
engine/engine_ctrl.sv
engine/lane_array.sv
engine/writeback.sv
source/cnn_engine_top.sv
verif/cnn_engine_tb.sv

/* Bender.yml */
package:
  name: cnn_engine

sources:
  - files:
      - common/engine_op_pkg.sv
      - common/engine_data_pkg.sv
      - engine/engine_ctrl.sv
      - engine/lane_array.sv
      - engine/writeback.sv
      - source/cnn_engine_top.sv
  - target: test
    files:
      - verif/cnn_engine_tb.sv
